// ==== verilog.f ====
vng_pkg.sv
vng_sum_if.sv
vng_sched_rom.sv
vng_sum_accum.sv
vng_diff_norm.sv
vng_diff_top.sv
tb_vng_diff.sv

// ==== Makefile ====
# Verilator build and run for the VNG colour-difference stage

TOOL      = verilator
TOP       = tb_vng_diff
FILELIST  = verilog.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       = sim.log
PASS_MSG  = SIMULATION PASSED

.PHONY: help test build clean

help:
	@echo "available targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench, run it and check the log"
	@echo "  clean  remove build output and the log"

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) -o V$(TOP)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "test target: passed"; \
	else \
		echo "test target: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_vng_diff.sv ====
module tb_vng_diff
    import vng_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 4;
    localparam int stretch_len = 25;

    // stimulus modes for one pixel slot
    localparam int mode_random = 0;
    localparam int mode_max    = 1;
    localparam int mode_full   = 2;
    localparam int mode_empty  = 3;
    localparam int mode_late   = 4;

    localparam int lead_slots      = 6;
    localparam int main_slots      = 24;
    localparam int total_slots     = lead_slots + 4 + main_slots;
    // 80 percent enable gives about 15 cycles per slot
    localparam int watchdog_cycles = (total_slots + 2) * slot_len * 2 + 3 * stretch_len + 100;

    logic                     clk;
    logic                     reset;
    logic                     clk_en;
    logic                     sample_valid;
    logic [data_w-1:0]        sample_red;
    logic [data_w-1:0]        sample_green;
    logic [data_w-1:0]        sample_blue;
    logic                     diff_valid;
    diff_kind_t               diff_kind;
    logic signed [norm_w-1:0] diff_norm;

    // reference model state
    int                       model_st;
    int                       acc_red;
    int                       acc_green;
    int                       acc_blue;
    int                       acc_cnt;
    int                       slots_done;
    int                       strobes_seen;
    logic signed [norm_w-1:0] exp_norm_q [$];
    diff_kind_t               exp_kind_q [$];
    logic                     head_valid = 1'b0;
    logic signed [norm_w-1:0] head_norm;
    diff_kind_t               head_kind;

    int                       value_errors;
    int                       kind_errors;
    int                       protocol_errors;

    vng_diff_top dut0 (
        .clk          ( clk ),
        .reset        ( reset ),
        .clk_en       ( clk_en ),
        .sample_valid ( sample_valid ),
        .sample_red   ( sample_red ),
        .sample_green ( sample_green ),
        .sample_blue  ( sample_blue ),
        .diff_valid   ( diff_valid ),
        .diff_kind    ( diff_kind ),
        .diff_norm    ( diff_norm )
    );

    initial clk = 1'b0;
    always #half_period clk = ~clk;

    // (a - b) * recip_scale[n] / 2^15, floored, kept to norm_w bits
    function automatic logic signed [norm_w-1:0] expected_norm(input int a, input int b,
                                                               input int n);
        longint d;
        longint p;
        d = longint'(a) - longint'(b);
        p = d * longint'(recip_scale[n]);
        p = p >>> scale_shift;
        expected_norm = p[norm_w-1:0];
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            model_st     = 0;
            acc_red      = 0;
            acc_green    = 0;
            acc_blue     = 0;
            acc_cnt      = 0;
            slots_done   = 0;
            strobes_seen = 0;
            exp_norm_q.delete();
            exp_kind_q.delete();
        end else begin
            if (diff_valid) begin
                strobes_seen++;
                if (exp_norm_q.size() > 0) begin
                    void'(exp_norm_q.pop_front());
                    void'(exp_kind_q.pop_front());
                end
            end
            if (clk_en) begin
                if (sample_valid && model_st < sample_states) begin
                    acc_red   += int'(sample_red);
                    acc_green += int'(sample_green);
                    acc_blue  += int'(sample_blue);
                    acc_cnt++;
                end
                if (model_st == slot_len - 1) begin
                    // both results of this pixel come out during the next slot
                    exp_norm_q.push_back(expected_norm(acc_red, acc_green, acc_cnt));
                    exp_kind_q.push_back(kind_rg);
                    exp_norm_q.push_back(expected_norm(acc_blue, acc_green, acc_cnt));
                    exp_kind_q.push_back(kind_bg);
                    slots_done++;
                    acc_red   = 0;
                    acc_green = 0;
                    acc_blue  = 0;
                    acc_cnt   = 0;
                    model_st  = 0;
                end else begin
                    model_st++;
                end
            end
        end
        head_valid <= (exp_norm_q.size() > 0);
        if (exp_norm_q.size() > 0) begin
            head_norm <= exp_norm_q[0];
            head_kind <= exp_kind_q[0];
        end
    end

    a_quiet_in_reset: assert property (@(posedge clk) reset |-> !diff_valid)
        else begin
            protocol_errors++;
            $display("diff_valid was asserted during reset");
        end

    a_quiet_when_held: assert property (@(posedge clk) !clk_en |-> !diff_valid)
        else begin
            protocol_errors++;
            $display("diff_valid was asserted while clk_en was low");
        end

    a_quiet_before_ready: assert property (@(posedge clk) disable iff (reset)
        (slots_done == 0) |-> !diff_valid)
        else begin
            protocol_errors++;
            $display("diff_valid was asserted before the first slot completed");
        end

    a_result_expected: assert property (@(posedge clk) disable iff (reset)
        diff_valid |-> head_valid)
        else begin
            protocol_errors++;
            $display("diff_valid strobe seen with no expected result pending");
        end

    a_norm_value: assert property (@(posedge clk) disable iff (reset)
        (diff_valid && head_valid) |-> (diff_norm == head_norm))
        else begin
            value_errors++;
            $display("Error: diff_norm = 0x%h, expected 0x%h",
                     $sampled(diff_norm), $sampled(head_norm));
        end

    a_kind_value: assert property (@(posedge clk) disable iff (reset)
        (diff_valid && head_valid) |-> (diff_kind == head_kind))
        else begin
            kind_errors++;
            $display("Error: diff_kind = 0x%h, expected 0x%h",
                     $sampled(diff_kind), $sampled(head_kind));
        end

    // inputs for one cycle, clk_en high about 80 percent of the time
    task automatic drive_cycle(input int mode);
        clk_en       = (($urandom() % 10) < 8);
        sample_red   = data_w'($urandom());
        sample_green = data_w'($urandom());
        sample_blue  = data_w'($urandom());
        case (mode)
            mode_max: begin
                sample_valid = 1'b1;
                sample_red   = '1;
                sample_green = '1;
                sample_blue  = '1;
            end
            mode_full: begin
                sample_valid = 1'b1;
                sample_red   = '1;
                sample_green = '0;
                sample_blue  = '0;
            end
            mode_empty: sample_valid = 1'b0;
            // strobes only where the slot ignores them
            mode_late:  sample_valid = (model_st >= sample_states);
            default:    sample_valid = 1'(($urandom() % 2));
        endcase
    endtask

    // one complete slot, optionally with a long clk_en low stretch at a state
    task automatic run_slot(input int mode, input int stretch_at);
        bit done;
        bit stretched;
        int hold_left;
        done      = 1'b0;
        stretched = 1'b0;
        hold_left = 0;
        while (!done) begin
            @(posedge clk);
            #1;
            if (!stretched && model_st == stretch_at) begin
                stretched = 1'b1;
                hold_left = stretch_len;
            end
            if (hold_left > 0) begin
                hold_left--;
                drive_cycle(mode_random);
                clk_en = 1'b0;
            end else begin
                drive_cycle(mode);
                if (clk_en && model_st == slot_len - 1) begin
                    done = 1'b1;
                end
            end
        end
    endtask

    initial begin
        value_errors    = 0;
        kind_errors     = 0;
        protocol_errors = 0;
        void'($urandom(1215));
        reset           = 1'b1;
        clk_en          = 1'b0;
        sample_valid    = 1'b0;
        sample_red      = '0;
        sample_green    = '0;
        sample_blue     = '0;
        @(posedge clk);
        #1;
        // enabled cycles and strobes inside reset
        clk_en       = 1'b1;
        sample_valid = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset        = 1'b0;
        clk_en       = 1'b0;
        sample_valid = 1'b0;

        for (int i = 0; i < lead_slots; i++) begin
            run_slot(mode_random, -1);
        end
        run_slot(mode_max, -1);
        run_slot(mode_full, -1);
        run_slot(mode_empty, -1);
        run_slot(mode_late, -1);

        // stretches before sampling ends, between the two strobes, and late
        for (int i = 0; i < main_slots; i++) begin
            if (i == 5) begin
                run_slot(mode_random, 3);
            end else if (i == 12) begin
                run_slot(mode_random, 6);
            end else if (i == 18) begin
                run_slot(mode_random, 10);
            end else begin
                run_slot(mode_random, -1);
            end
        end

        // let the last pixel's results come out
        while (model_st != sample_states) begin
            @(posedge clk);
            #1;
            drive_cycle(mode_empty);
        end

        assert (exp_norm_q.size() == 0)
            else begin
                protocol_errors++;
                $display("%0d expected results never appeared", exp_norm_q.size());
            end
        assert (strobes_seen == 2 * slots_done)
            else begin
                protocol_errors++;
                $display("Error: diff_valid strobes = 0x%h, expected 0x%h",
                         strobes_seen, 2 * slots_done);
            end

        $display("errors: value %0d, kind %0d, protocol %0d (%0d strobes over %0d slots)",
                 value_errors, kind_errors, protocol_errors, strobes_seen, slots_done);
        if (value_errors + kind_errors + protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== vng_diff_top.sv ====
module vng_diff_top
    import vng_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clk_en,

    // neighbour contributions
    input  logic                     sample_valid,
    input  logic [data_w-1:0]        sample_red,
    input  logic [data_w-1:0]        sample_green,
    input  logic [data_w-1:0]        sample_blue,

    // normalized colour differences
    output logic                     diff_valid,
    output diff_kind_t               diff_kind,
    output logic signed [norm_w-1:0] diff_norm
);

    vng_sum_if sums_if ();

    vng_sum_accum accum0 (
        .clk          ( clk ),
        .reset        ( reset ),
        .clk_en       ( clk_en ),
        .sample_valid ( sample_valid ),
        .sample_red   ( sample_red ),
        .sample_green ( sample_green ),
        .sample_blue  ( sample_blue ),
        .sums         ( sums_if.src )
    );

    vng_diff_norm norm0 (
        .clk        ( clk ),
        .reset      ( reset ),
        .clk_en     ( clk_en ),
        .sums       ( sums_if.dst ),
        .diff_valid ( diff_valid ),
        .diff_kind  ( diff_kind ),
        .diff_norm  ( diff_norm )
    );

endmodule

// ==== vng_diff_norm.sv ====
module vng_diff_norm
    import vng_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clk_en,

    vng_sum_if.dst                   sums,

    output logic                     diff_valid,
    output diff_kind_t               diff_kind,
    output logic signed [norm_w-1:0] diff_norm
);

    localparam int prod_w = sum_w + 1 + scale_w;

    col_sel_t a_sel;
    col_sel_t b_sel;
    logic     scale_en;
    logic     out_en;

    // schedules below are listed from st 11 down to st 0
    // a: red at st 0, blue at st 1, red elsewhere
    vng_sched_rom #(
        .entry_t ( col_sel_t ),
        .entries ( {sel_red, sel_red, sel_red, sel_red, sel_red, sel_red,
                    sel_red, sel_red, sel_red, sel_red, sel_red, sel_blue} )
    ) a_sel_rom (
        .clk    ( clk ),
        .clk_en ( clk_en ),
        .st     ( sums.st ),
        .entry  ( a_sel )
    );

    // b: green for both differences, red while idle
    vng_sched_rom #(
        .entry_t ( col_sel_t ),
        .entries ( {sel_green, sel_red, sel_red, sel_red, sel_red, sel_red,
                    sel_red, sel_red, sel_red, sel_red, sel_red, sel_green} )
    ) b_sel_rom (
        .clk    ( clk ),
        .clk_en ( clk_en ),
        .st     ( sums.st ),
        .entry  ( b_sel )
    );

    // pick up the new count at st 0
    vng_sched_rom #(
        .entry_t ( logic ),
        .entries ( 12'b1000_0000_0000 )
    ) scale_en_rom (
        .clk    ( clk ),
        .clk_en ( clk_en ),
        .st     ( sums.st ),
        .entry  ( scale_en )
    );

    // output load at st 5 and 6
    vng_sched_rom #(
        .entry_t ( logic ),
        .entries ( 12'b0000_0011_0000 )
    ) out_en_rom (
        .clk    ( clk ),
        .clk_en ( clk_en ),
        .st     ( sums.st ),
        .entry  ( out_en )
    );

    function automatic logic [sum_w-1:0] pick(
        input col_sel_t         sel,
        input logic [sum_w-1:0] red,
        input logic [sum_w-1:0] green,
        input logic [sum_w-1:0] blue
    );
        case (sel)
            sel_green: pick = green;
            sel_blue:  pick = blue;
            default:   pick = red;
        endcase
    endfunction

    logic        [sum_w-1:0]   op_a;
    logic        [sum_w-1:0]   op_b;
    logic        [sum_w:0]     diff;
    logic        [scale_w-1:0] scale;
    logic signed [sum_w:0]     mult_a;
    logic signed [scale_w-1:0] mult_b;
    logic signed [prod_w-1:0]  prod0;
    logic signed [prod_w-1:0]  prod;

    // datapath pipeline
    always_ff @(posedge clk) begin
        if (clk_en) begin
            op_a <= pick(a_sel, sums.red_sum, sums.green_sum, sums.blue_sum);
            op_b <= pick(b_sel, sums.red_sum, sums.green_sum, sums.blue_sum);

            // one extra bit keeps the sign of a - b
            diff <= {1'b0, op_a} - {1'b0, op_b};

            if (scale_en) begin
                scale <= recip_scale[sums.cnt];
            end

            mult_a <= diff;
            mult_b <= scale;
            prod0  <= mult_a * mult_b;
            prod   <= prod0;

            // divide by 2^15, floor
            if (out_en) begin
                diff_norm <= prod[scale_shift +: norm_w];
            end
        end
    end

    logic       valid_q;
    diff_kind_t kind_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            diff_kind <= kind_rg;
            kind_next <= kind_rg;
        end else if (clk_en) begin
            // nothing valid until a full slot has been summed
            valid_q <= out_en && sums.ready;
            if (out_en) begin
                diff_kind <= kind_next;
                kind_next <= (kind_next == kind_rg) ? kind_bg : kind_rg;
            end
        end
    end

    // strobe only on enabled cycles
    assign diff_valid = valid_q && clk_en;

endmodule

// ==== vng_sum_accum.sv ====
module vng_sum_accum
    import vng_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              clk_en,

    input  logic              sample_valid,
    input  logic [data_w-1:0] sample_red,
    input  logic [data_w-1:0] sample_green,
    input  logic [data_w-1:0] sample_blue,

    vng_sum_if.src            sums
);

    localparam st_t last_st = st_t'(slot_len - 1);

    // running totals of the slot in progress
    logic [sum_w-1:0] red_acc;
    logic [sum_w-1:0] green_acc;
    logic [sum_w-1:0] blue_acc;
    logic [cnt_w-1:0] cnt_acc;

    logic             take;
    logic [sum_w-1:0] red_next;
    logic [sum_w-1:0] green_next;
    logic [sum_w-1:0] blue_next;
    logic [cnt_w-1:0] cnt_next;

    // only the leading states of a slot accept samples
    assign take = sample_valid && (sums.st < st_t'(sample_states));

    always_comb begin
        red_next   = red_acc;
        green_next = green_acc;
        blue_next  = blue_acc;
        cnt_next   = cnt_acc;
        if (take) begin
            red_next   = red_acc + sum_w'(sample_red);
            green_next = green_acc + sum_w'(sample_green);
            blue_next  = blue_acc + sum_w'(sample_blue);
            cnt_next   = cnt_acc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sums.st        <= '0;
            sums.ready     <= 1'b0;
            sums.red_sum   <= '0;
            sums.green_sum <= '0;
            sums.blue_sum  <= '0;
            sums.cnt       <= '0;
            red_acc        <= '0;
            green_acc      <= '0;
            blue_acc       <= '0;
            cnt_acc        <= '0;
        end else if (clk_en) begin
            if (sums.st == last_st) begin
                // slot end: hand totals over, start the next pixel
                sums.st        <= '0;
                sums.ready     <= 1'b1;
                sums.red_sum   <= red_next;
                sums.green_sum <= green_next;
                sums.blue_sum  <= blue_next;
                sums.cnt       <= cnt_next;
                red_acc        <= '0;
                green_acc      <= '0;
                blue_acc       <= '0;
                cnt_acc        <= '0;
            end else begin
                sums.st   <= sums.st + 1'b1;
                red_acc   <= red_next;
                green_acc <= green_next;
                blue_acc  <= blue_next;
                cnt_acc   <= cnt_next;
            end
        end
    end

endmodule

// ==== vng_sched_rom.sv ====
module vng_sched_rom
    import vng_pkg::*;
#(
    parameter type entry_t = logic,
    // entries packed with st 0 in the low bits
    parameter logic [slot_len*$bits(entry_t)-1:0] entries = '0
) (
    input  logic   clk,
    input  logic   clk_en,
    input  st_t    st,
    output entry_t entry
);

    localparam int entry_w = $bits(entry_t);

    logic [entry_w-1:0] raw;

    // lookup for the current state
    always_comb begin
        raw = entries[st*entry_w +: entry_w];
    end

    // registered, so entry k acts during state k+1
    always_ff @(posedge clk) begin
        if (clk_en) begin
            entry <= entry_t'(raw);
        end
    end

endmodule

// ==== vng_sum_if.sv ====
interface vng_sum_if
    import vng_pkg::*;
();

    // totals of the last completed slot
    logic [sum_w-1:0] red_sum;
    logic [sum_w-1:0] green_sum;
    logic [sum_w-1:0] blue_sum;
    logic [cnt_w-1:0] cnt;

    // current slot state
    st_t              st;
    // high once the first slot has completed
    logic             ready;

    modport src (
        output red_sum, green_sum, blue_sum, cnt, st, ready
    );

    modport dst (
        input  red_sum, green_sum, blue_sum, cnt, st, ready
    );

endinterface

// ==== vng_pkg.sv ====
package vng_pkg;

    // sample and sum widths
    localparam int data_w = 8;
    // room for up to 8 samples per colour
    localparam int sum_w  = data_w + 4;
    // signed normalized difference
    localparam int norm_w = data_w + 1;
    // contribution count, 0 to 8
    localparam int cnt_w  = 4;

    // pixel slot timing
    localparam int slot_len      = 12;
    localparam int sample_states = 8;

    typedef logic [3:0] st_t;

    // reciprocal scaling for the post-divide
    localparam int scale_w     = 16;
    localparam int scale_shift = 15;

    // 2^14 / cnt, rounded down
    // msb stays clear so the value is safe in a signed multiply
    localparam logic [scale_w-1:0] recip_scale [0:8] = '{
        16'd0,
        16'd16384,
        16'd8192,
        16'd5461,
        16'd4096,
        16'd3276,
        16'd2730,
        16'd2340,
        16'd2048
    };

    // operand selector for the difference stage
    typedef enum logic [1:0] {
        sel_red,
        sel_green,
        sel_blue
    } col_sel_t;

    // which difference a result carries
    typedef enum logic {
        kind_rg,
        kind_bg
    } diff_kind_t;

endpackage
